// ==== logic/adc_frame_consts.svh ====
`ifndef ADC_FRAME_CONSTS_SVH
`define ADC_FRAME_CONSTS_SVH

// data widths

`define SAMPLE_W      16                // bits per channel value
`define CHANNELS      8                 // channels per bank
`define WORD_W        32                // stream word width
`define CTRL_W        32                // width of the control inputs

// record layout

`define RECORD_WORDS  12                // words per sample set
`define MARKER_WORD   (32'hFFFF_FFFF)   // separator around the index words
`define INDEX_WORD_LO (32'h7654_3210)   // channel numbers 7..0, one nibble each
`define INDEX_WORD_HI (32'hFEDC_BA98)   // channel numbers 15..8

// buffering and timing

`define FIFO_DEPTH    32                // default stream fifo depth, power of two
`define MIN_PERIOD    16                // record must finish before next convst

`endif

// ==== logic/adc_frame_pkg.sv ====
`include "adc_frame_consts.svh"

package adc_frame_pkg;

	typedef logic [`CTRL_W-1:0] ctrl_word_t;    // control inputs and frame counters
	typedef logic [`WORD_W-1:0] stream_word_t;  // one fifo / axis word

	// eight channel values of one bank, ch1 at index 0
	typedef logic [`CHANNELS-1:0][`SAMPLE_W-1:0] adc_bank_t;

	// both banks of one conversion
	typedef struct packed {
		adc_bank_t bank_a;
		adc_bank_t bank_b;
	} sample_set_t;

	// settings latched at frame start
	typedef struct packed {
		ctrl_word_t total_words;  // sampling_points * record length
		logic       last_frame;   // tlast wanted on final word
	} frame_cfg_t;

	// sticky error flags, cleared at each frame start
	typedef struct packed {
		logic missed_sample;
		logic fifo_overflow;
	} err_flags_t;

endpackage

// ==== logic/frame_sequencer.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module frame_sequencer (
	input  logic                      M_AXIS_ACLK,
	input  logic                      adc_rst_n,
	input  logic                      trigger,                 // asynchronous level
	input  adc_frame_pkg::ctrl_word_t sampling_points,
	input  adc_frame_pkg::ctrl_word_t sampling_clk_increment,
	input  logic                      last_frame,
	input  logic                      frame_done,              // last word accepted downstream
	output logic                      frame_start,
	output adc_frame_pkg::frame_cfg_t frame_cfg,
	output logic                      convst,
	output logic                      ready
);
	import adc_frame_pkg::*;

	localparam int DRAIN_TIMEOUT = 4096;  // cycles after last convst before giving up on frame_done

	typedef enum logic [1:0] {
		seq_idle,
		seq_sample,
		seq_drain
	} seq_state_t;

	seq_state_t state;
	logic [1:0] trig_sync;    // two stage synchronizer
	logic       trig_prev;
	logic       start_req;
	ctrl_word_t period_q;     // latched sampling_clk_increment
	ctrl_word_t period_cnt;   // zero means convst goes out next cycle
	ctrl_word_t points_left;  // conversions still to issue
	logic [$clog2(DRAIN_TIMEOUT)-1:0] drain_cnt;

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			trig_sync <= '0;
			trig_prev <= 1'b0;
		end else begin
			trig_sync <= {trig_sync[0], trigger};
			trig_prev <= trig_sync[1];
		end
	end

	// rising edge seen only while idle, empty frames are ignored
	assign start_req = (state == seq_idle) && trig_sync[1] && !trig_prev
		&& (sampling_points != '0);

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			state       <= seq_idle;
			frame_start <= 1'b0;
			convst      <= 1'b0;
			ready       <= 1'b1;
			period_cnt  <= '0;
			points_left <= '0;
			drain_cnt   <= '0;
		end else begin
			frame_start <= 1'b0;  // both strobes last one cycle
			convst      <= 1'b0;
			case (state)
				seq_idle: begin
					if (start_req) begin
						state       <= seq_sample;
						frame_start <= 1'b1;
						ready       <= 1'b0;  // falls together with frame_start
						period_cnt  <= '0;    // first convst right after frame_start
						points_left <= sampling_points;
					end
				end
				seq_sample: begin
					if (period_cnt == '0) begin
						convst      <= 1'b1;
						period_cnt  <= period_q - 1'b1;
						points_left <= points_left - 1'b1;
						if (points_left == ctrl_word_t'(1)) begin
							state     <= seq_drain;  // all conversions issued
							drain_cnt <= '0;
						end
					end else begin
						period_cnt <= period_cnt - 1'b1;
					end
				end
				seq_drain: begin
					drain_cnt <= drain_cnt + 1'b1;
					// lost words never reach the count, so a stuck frame times out
					if (frame_done || drain_cnt == '1) begin
						state <= seq_idle;
						ready <= 1'b1;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (start_req) begin
			period_q              <= sampling_clk_increment;
			frame_cfg.total_words <= ctrl_word_t'(sampling_points * `RECORD_WORDS);
			frame_cfg.last_frame  <= last_frame;
		end
	end

	// shorter periods would let a new record overlap the one being packed
	period_min_a: assert property (@(posedge M_AXIS_ACLK) disable iff (!adc_rst_n)
		frame_start |-> period_q >= `MIN_PERIOD)
		else $error("sample period below minimum");

endmodule

// ==== logic/sample_capture.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module sample_capture (
	input  logic                       M_AXIS_ACLK,
	input  logic                       adc_rst_n,
	input  logic                       frame_start,
	input  logic                       convst,
	input  adc_frame_pkg::adc_bank_t   bank_a,
	input  logic                       bank_a_valid,   // bank a finished its conversion
	input  adc_frame_pkg::adc_bank_t   bank_b,
	input  logic                       bank_b_valid,
	output logic                       set_valid,
	output adc_frame_pkg::sample_set_t set_data,
	output logic                       missed_sample   // sticky until frame_start
);
	import adc_frame_pkg::*;

	logic pending;   // conversion outstanding
	logic have_a;    // bank a already captured for it
	logic have_b;
	logic got_a;
	logic got_b;
	logic joined;    // both banks present this cycle

	assign got_a  = have_a || bank_a_valid;
	assign got_b  = have_b || bank_b_valid;
	assign joined = pending && got_a && got_b;

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			pending       <= 1'b0;
			have_a        <= 1'b0;
			have_b        <= 1'b0;
			set_valid     <= 1'b0;
			missed_sample <= 1'b0;
		end else begin
			set_valid <= joined;  // one cycle after the later bank
			if (frame_start) begin
				pending       <= 1'b0;
				have_a        <= 1'b0;
				have_b        <= 1'b0;
				missed_sample <= 1'b0;
			end else if (joined) begin
				have_a  <= 1'b0;
				have_b  <= 1'b0;
				pending <= convst;  // back to back convst opens the next one
			end else if (convst) begin
				if (pending)
					missed_sample <= 1'b1;  // overtaken, half set is dropped
				pending <= 1'b1;
				have_a  <= 1'b0;
				have_b  <= 1'b0;
			end else if (pending) begin
				have_a <= got_a;
				have_b <= got_b;
			end
		end
	end

	// output holds the joined set until the next bank strobe
	always_ff @(posedge M_AXIS_ACLK) begin
		if (pending && bank_a_valid)
			set_data.bank_a <= bank_a;
		if (pending && bank_b_valid)
			set_data.bank_b <= bank_b;
	end

	// banks only answer a convst issued earlier by the sequencer
	bank_pending_a: assert property (@(posedge M_AXIS_ACLK) disable iff (!adc_rst_n)
		(bank_a_valid || bank_b_valid) |-> pending)
		else $error("bank strobe without a pending conversion");

endmodule

// ==== logic/record_packer.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module record_packer (
	input  logic                        M_AXIS_ACLK,
	input  logic                        adc_rst_n,
	input  logic                        set_valid,
	input  adc_frame_pkg::sample_set_t  set_data,
	output logic                        word_valid,  // high for the twelve record words
	output adc_frame_pkg::stream_word_t word_data
);
	import adc_frame_pkg::*;

	sample_set_t set_q;      // set being packed
	logic [3:0]  word_idx;   // position inside the record
	logic [1:0]  pair;       // channel pair 0..3
	adc_bank_t   pair_bank;  // bank a for words 0..3, bank b for 4..7

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n) begin
			word_valid <= 1'b0;
			word_idx   <= '0;
		end else if (set_valid) begin
			word_valid <= 1'b1;  // first word on the next cycle
			word_idx   <= '0;
		end else if (word_valid) begin
			if (word_idx == 4'(`RECORD_WORDS - 1)) begin
				word_valid <= 1'b0;
				word_idx   <= '0;
			end else begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (set_valid)
			set_q <= set_data;
	end

	assign pair      = word_idx[1:0];
	assign pair_bank = word_idx[2] ? set_q.bank_b : set_q.bank_a;

	always_comb begin
		case (word_idx)
			4'd8, 4'd11: word_data = `MARKER_WORD;
			4'd9:        word_data = `INDEX_WORD_LO;
			4'd10:       word_data = `INDEX_WORD_HI;
			default:     word_data = {pair_bank[{pair, 1'b1}], pair_bank[{pair, 1'b0}]};  // {ch2n, ch2n-1}
		endcase
	end

	// sets arrive at least one period apart, so a record never gets cut short
	no_overlap_a: assert property (@(posedge M_AXIS_ACLK) disable iff (!adc_rst_n)
		set_valid |-> !word_valid || word_idx == 4'(`RECORD_WORDS - 1))
		else $error("sample set arrived while a record was being packed");

endmodule

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module stream_fifo #(
	parameter int DEPTH = `FIFO_DEPTH  // power of two
) (
	input  logic                        M_AXIS_ACLK,
	input  logic                        adc_rst_n,
	input  logic                        flush,      // drop contents, clear overflow
	input  logic                        push,
	input  adc_frame_pkg::stream_word_t push_data,
	input  logic                        pop,
	output adc_frame_pkg::stream_word_t pop_data,   // head word, valid while not empty
	output logic                        empty,
	output logic                        overflow    // sticky, a push was lost
);
	import adc_frame_pkg::*;

	localparam int AW = $clog2(DEPTH);

	stream_word_t  mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign empty   = (count == '0);
	assign full    = count[AW];               // count reaches DEPTH
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);  // a pop frees the slot this cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n || flush) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && !do_push)
				overflow <= 1'b1;  // word lost
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// the stream side only pops what it saw as available
	pop_nonempty_a: assert property (@(posedge M_AXIS_ACLK) disable iff (!adc_rst_n)
		pop |-> !empty)
		else $error("pop from empty fifo");

endmodule

// ==== logic/stream_out.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module stream_out (
	input  logic                        M_AXIS_ACLK,
	input  logic                        adc_rst_n,
	input  logic                        frame_start,
	input  adc_frame_pkg::frame_cfg_t   frame_cfg,
	input  adc_frame_pkg::stream_word_t fifo_data,
	input  logic                        fifo_empty,
	input  logic                        M_AXIS_TREADY,
	output logic                        pop,
	output logic                        M_AXIS_TVALID,
	output adc_frame_pkg::stream_word_t M_AXIS_TDATA,
	output logic                        M_AXIS_TLAST,
	output logic                        frame_done   // final word accepted
);
	import adc_frame_pkg::*;

	logic              accept;      // axis handshake this cycle
	logic [`CTRL_W-1:0] sent_cnt;   // words accepted in this frame
	logic [`CTRL_W-1:0] load_idx;   // frame position of a word popped now
	logic              load_final;
	logic              final_q;     // register holds the frame's last word

	assign accept     = M_AXIS_TVALID && M_AXIS_TREADY;
	assign pop        = !fifo_empty && (!M_AXIS_TVALID || accept);  // refill empty or leaving reg
	assign load_idx   = M_AXIS_TVALID ? sent_cnt + 1'b1 : sent_cnt;
	assign load_final = (load_idx == frame_cfg.total_words - 1'b1);
	assign frame_done = accept && final_q;

	always_ff @(posedge M_AXIS_ACLK) begin
		if (!adc_rst_n || frame_start) begin
			M_AXIS_TVALID <= 1'b0;  // leftovers of an aborted frame are dropped
			M_AXIS_TLAST  <= 1'b0;
			final_q       <= 1'b0;
			sent_cnt      <= '0;
		end else begin
			if (accept)
				sent_cnt <= sent_cnt + 1'b1;
			if (pop) begin
				M_AXIS_TVALID <= 1'b1;
				final_q       <= load_final;
				M_AXIS_TLAST  <= load_final && frame_cfg.last_frame;
			end else if (accept) begin
				M_AXIS_TVALID <= 1'b0;  // nothing to follow yet
				final_q       <= 1'b0;
				M_AXIS_TLAST  <= 1'b0;
			end
		end
	end

	always_ff @(posedge M_AXIS_ACLK) begin
		if (pop)
			M_AXIS_TDATA <= fifo_data;  // held until accepted
	end

endmodule

// ==== logic/adc_frame_top.sv ====
`timescale 1ns/1ns

module adc_frame_top (
	input  logic                        M_AXIS_ACLK,
	input  logic                        adc_rst_n,
	input  logic                        trigger,                 // rising edge starts a frame
	input  adc_frame_pkg::ctrl_word_t   sampling_points,
	input  adc_frame_pkg::ctrl_word_t   sampling_clk_increment,  // cycles between convst
	input  logic                        last_frame,
	input  adc_frame_pkg::adc_bank_t    bank_a,
	input  logic                        bank_a_valid,
	input  adc_frame_pkg::adc_bank_t    bank_b,
	input  logic                        bank_b_valid,
	input  logic                        M_AXIS_TREADY,
	output logic                        convst,
	output logic                        ready,
	output adc_frame_pkg::err_flags_t   error_flags,
	output logic                        M_AXIS_TVALID,
	output adc_frame_pkg::stream_word_t M_AXIS_TDATA,
	output logic                        M_AXIS_TLAST
);
	import adc_frame_pkg::*;

	logic         frame_start;    // one cycle, also flushes fifo
	logic         frame_done;
	frame_cfg_t   frame_cfg;
	logic         set_valid;
	sample_set_t  set_data;
	logic         word_valid;
	stream_word_t word_data;
	logic         pop;
	stream_word_t fifo_data;
	logic         fifo_empty;
	logic         missed_flag;
	logic         overflow_flag;

	assign error_flags = '{missed_sample: missed_flag, fifo_overflow: overflow_flag};

	frame_sequencer frame_sequencer_inst (
		.M_AXIS_ACLK            (M_AXIS_ACLK),
		.adc_rst_n              (adc_rst_n),
		.trigger                (trigger),
		.sampling_points        (sampling_points),
		.sampling_clk_increment (sampling_clk_increment),
		.last_frame             (last_frame),
		.frame_done             (frame_done),
		.frame_start            (frame_start),
		.frame_cfg              (frame_cfg),
		.convst                 (convst),
		.ready                  (ready)
	);

	sample_capture sample_capture_inst (
		.M_AXIS_ACLK   (M_AXIS_ACLK),
		.adc_rst_n     (adc_rst_n),
		.frame_start   (frame_start),
		.convst        (convst),
		.bank_a        (bank_a),
		.bank_a_valid  (bank_a_valid),
		.bank_b        (bank_b),
		.bank_b_valid  (bank_b_valid),
		.set_valid     (set_valid),
		.set_data      (set_data),
		.missed_sample (missed_flag)
	);

	record_packer record_packer_inst (
		.M_AXIS_ACLK (M_AXIS_ACLK),
		.adc_rst_n   (adc_rst_n),
		.set_valid   (set_valid),
		.set_data    (set_data),
		.word_valid  (word_valid),
		.word_data   (word_data)
	);

	stream_fifo stream_fifo_inst (
		.M_AXIS_ACLK (M_AXIS_ACLK),
		.adc_rst_n   (adc_rst_n),
		.flush       (frame_start),
		.push        (word_valid),
		.push_data   (word_data),
		.pop         (pop),
		.pop_data    (fifo_data),
		.empty       (fifo_empty),
		.overflow    (overflow_flag)
	);

	stream_out stream_out_inst (
		.M_AXIS_ACLK   (M_AXIS_ACLK),
		.adc_rst_n     (adc_rst_n),
		.frame_start   (frame_start),
		.frame_cfg     (frame_cfg),
		.fifo_data     (fifo_data),
		.fifo_empty    (fifo_empty),
		.M_AXIS_TREADY (M_AXIS_TREADY),
		.pop           (pop),
		.M_AXIS_TVALID (M_AXIS_TVALID),
		.M_AXIS_TDATA  (M_AXIS_TDATA),
		.M_AXIS_TLAST  (M_AXIS_TLAST),
		.frame_done    (frame_done)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n      // active low, released on a falling edge
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end
endmodule

// ==== verification/adc_frame_tb.sv ====
`timescale 1ns/1ns
`include "adc_frame_consts.svh"

module adc_frame_tb;
	import adc_frame_pkg::*;

	localparam int FIELDS        = 7;     // columns per stimulus line
	localparam int MAX_FRAMES    = 16;
	localparam int READY_TIMEOUT = 6000;  // longer than the sequencer drain limit
	localparam int DRAIN_TIMEOUT = 200;
	localparam int QUIET_CYCLES  = 8;

	logic         M_AXIS_ACLK;
	logic         adc_rst_n;
	logic         trigger = 1'b0;
	ctrl_word_t   sampling_points = '0;
	ctrl_word_t   sampling_clk_increment = '0;
	logic         last_frame = 1'b0;
	adc_bank_t    bank_a = '0;
	logic         bank_a_valid = 1'b0;
	adc_bank_t    bank_b = '0;
	logic         bank_b_valid = 1'b0;
	logic         M_AXIS_TREADY = 1'b0;
	logic         convst;
	logic         ready;
	err_flags_t   error_flags;
	logic         M_AXIS_TVALID;
	stream_word_t M_AXIS_TDATA;
	logic         M_AXIS_TLAST;

	logic [31:0]  stim_mem [MAX_FRAMES*FIELDS];
	stream_word_t exp_q [$];              // scoreboard, built from the bank model
	logic [31:0]  ch_rng = 32'h7c83;      // channel values
	logic [31:0]  ready_rng = 32'h7c83;   // random tready
	int           tready_mode = 2;        // 0 high, 1 random, 2 low
	int           frame_points = 0;
	int           frame_delay = 1;        // bank a delay, bank b answers 2 cycles later
	logic         frame_last = 1'b0;
	int           frame_id = 0;           // bumped by the main process per frame
	int           seen_id = 0;
	int           rx_count = 0;           // words accepted this frame
	int           convst_count = 0;
	logic         a_busy = 1'b0;          // bank converting, ignores convst
	logic         b_busy = 1'b0;
	int           a_cnt = 0;
	int           b_cnt = 0;
	adc_bank_t    a_vals = '0;
	adc_bank_t    b_vals = '0;

	tb_clock_gen clock_gen_inst (.clk(M_AXIS_ACLK), .rst_n(adc_rst_n));

	adc_frame_top adc_frame_top_inst (
		.M_AXIS_ACLK            (M_AXIS_ACLK),
		.adc_rst_n              (adc_rst_n),
		.trigger                (trigger),
		.sampling_points        (sampling_points),
		.sampling_clk_increment (sampling_clk_increment),
		.last_frame             (last_frame),
		.bank_a                 (bank_a),
		.bank_a_valid           (bank_a_valid),
		.bank_b                 (bank_b),
		.bank_b_valid           (bank_b_valid),
		.M_AXIS_TREADY          (M_AXIS_TREADY),
		.convst                 (convst),
		.ready                  (ready),
		.error_flags            (error_flags),
		.M_AXIS_TVALID          (M_AXIS_TVALID),
		.M_AXIS_TDATA           (M_AXIS_TDATA),
		.M_AXIS_TLAST           (M_AXIS_TLAST)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// eight channel values spread out of one random word
	function automatic adc_bank_t bank_from_word(input logic [31:0] r);
		adc_bank_t vals;
		for (int ch = 0; ch < `CHANNELS; ch++)
			vals[ch] = r[31:16] ^ (r[15:0] + 16'(ch) * 16'h1d35);
		return vals;
	endfunction

	// one record: bank a pairs, bank b pairs, marker, index words, marker
	task automatic push_record(input adc_bank_t a, input adc_bank_t b);
		for (int p = 0; p < `CHANNELS / 2; p++)
			exp_q.push_back({a[2*p+1], a[2*p]});
		for (int p = 0; p < `CHANNELS / 2; p++)
			exp_q.push_back({b[2*p+1], b[2*p]});
		exp_q.push_back(`MARKER_WORD);
		exp_q.push_back(`INDEX_WORD_LO);
		exp_q.push_back(`INDEX_WORD_HI);
		exp_q.push_back(`MARKER_WORD);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] %0t ns: %s is %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	task automatic await_ready(input logic level, input string what);
		int cycles;
		cycles = 0;
		@(negedge M_AXIS_ACLK);
		while (ready !== level) begin
			cycles++;
			if (cycles > READY_TIMEOUT)
				abort_run($sformatf("ready never went to %0d %s", level, what));
			else
				@(negedge M_AXIS_ACLK);
		end
	endtask

	task automatic drain_stream();
		int cycles;
		cycles = 0;
		@(negedge M_AXIS_ACLK);
		while (M_AXIS_TVALID === 1'b1) begin
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				abort_run("leftover words kept TVALID high for too long");
			else
				@(negedge M_AXIS_ACLK);
		end
	endtask

	// bank model, tready driver and stream monitor, all on the falling edge
	always @(negedge M_AXIS_ACLK) begin
		if (frame_id != seen_id) begin  // new frame, fresh scoreboard
			seen_id      = frame_id;
			rx_count     = 0;
			convst_count = 0;
			exp_q.delete();
		end
		bank_a_valid = 1'b0;
		bank_b_valid = 1'b0;
		if (adc_rst_n) begin
			if (convst)
				convst_count++;
			if (a_busy) begin
				a_cnt--;
				if (a_cnt == 0) begin
					bank_a       = a_vals;
					bank_a_valid = 1'b1;
					a_busy       = 1'b0;
				end
			end
			if (b_busy) begin
				b_cnt--;
				if (b_cnt == 0) begin
					bank_b       = b_vals;
					bank_b_valid = 1'b1;
					b_busy       = 1'b0;
					push_record(a_vals, b_vals);  // set complete once bank b is back
				end
			end
			if (convst && !a_busy) begin
				a_busy = 1'b1;
				a_cnt  = frame_delay;
				ch_rng = xorshift32(ch_rng);
				a_vals = bank_from_word(ch_rng);
			end
			if (convst && !b_busy) begin
				b_busy = 1'b1;
				b_cnt  = frame_delay + 2;
				ch_rng = xorshift32(ch_rng);
				b_vals = bank_from_word(ch_rng);
			end
		end
		case (tready_mode)
			0: M_AXIS_TREADY = 1'b1;
			1: begin
				ready_rng     = xorshift32(ready_rng);
				M_AXIS_TREADY = (ready_rng[1:0] != 2'b00);  // high three cycles in four
			end
			default: M_AXIS_TREADY = 1'b0;
		endcase
		if (M_AXIS_TVALID && M_AXIS_TREADY) begin  // word transfers on the next rising edge
			if (exp_q.size() == 0)
				abort_run("the stream delivered a word that no sample set produced");
			else begin
				check_equal("TDATA", M_AXIS_TDATA, exp_q.pop_front());
				check_equal("TLAST", 32'(M_AXIS_TLAST),
					32'(frame_last && rx_count == frame_points * `RECORD_WORDS - 1));
				rx_count++;
			end
		end
	end

	task automatic run_frame(input int base);
		int   pts;
		int   mode;
		logic exp_miss;
		logic exp_ovf;
		pts      = stim_mem[base];
		mode     = stim_mem[base+4];
		exp_miss = stim_mem[base+5][0];
		exp_ovf  = stim_mem[base+6][0];
		@(posedge M_AXIS_ACLK);
		frame_points = pts;
		frame_delay  = stim_mem[base+3];
		frame_last   = stim_mem[base+2][0];
		tready_mode  = 2;  // no leftover may be taken before frame_start
		frame_id++;
		@(negedge M_AXIS_ACLK);
		sampling_points        = stim_mem[base];
		sampling_clk_increment = stim_mem[base+1];
		last_frame             = stim_mem[base+2][0];
		trigger                = 1'b1;
		await_ready(1'b0, "after the trigger edge");
		@(posedge M_AXIS_ACLK);
		tready_mode = mode;
		@(negedge M_AXIS_ACLK);
		check_equal("error_flags after frame start", 32'(error_flags), 32'h0);
		trigger = 1'b0;
		repeat (3) @(negedge M_AXIS_ACLK);
		trigger = 1'b1;  // edge while busy
		repeat (3) @(negedge M_AXIS_ACLK);
		trigger = 1'b0;
		await_ready(1'b1, "at the end of the frame");
		check_equal("missed_sample", 32'(error_flags.missed_sample), 32'(exp_miss));
		check_equal("fifo_overflow", 32'(error_flags.fifo_overflow), 32'(exp_ovf));
		if (mode == 2) begin
			@(posedge M_AXIS_ACLK);
			tready_mode = 0;  // let the kept words out, still checked in order
			drain_stream();
			if (rx_count == 0 || rx_count >= pts * `RECORD_WORDS)
				abort_run("a held-off frame should keep some words and lose others");
		end else begin
			check_equal("words never delivered", exp_q.size(), 0);
			if (!exp_miss)
				check_equal("words in frame", rx_count, pts * `RECORD_WORDS);
		end
		@(posedge M_AXIS_ACLK);
		tready_mode = 2;
		repeat (QUIET_CYCLES) begin
			@(negedge M_AXIS_ACLK);
			check_equal("ready while idle", 32'(ready), 32'h1);
		end
		check_equal("convst count", convst_count, pts);  // no extra frame started
	endtask

	initial begin
		int f;
		int frames_run;
		int cycles;
		f          = 0;
		frames_run = 0;
		cycles     = 0;
		for (int i = 0; i < MAX_FRAMES * FIELDS; i++)
			stim_mem[i] = '0;
		$readmemh("verification/adc_frame_stim.txt", stim_mem);
		while (adc_rst_n !== 1'b1) begin
			cycles++;
			if (cycles > 20)
				abort_run("reset was never released");
			else
				@(negedge M_AXIS_ACLK);
		end
		@(negedge M_AXIS_ACLK);
		check_equal("ready after reset", 32'(ready), 32'h1);
		check_equal("TVALID after reset", 32'(M_AXIS_TVALID), 32'h0);
		check_equal("TLAST after reset", 32'(M_AXIS_TLAST), 32'h0);
		check_equal("error_flags after reset", 32'(error_flags), 32'h0);
		while (f < MAX_FRAMES && stim_mem[f*FIELDS] != '0) begin  // zero points ends the list
			run_frame(f * FIELDS);
			frames_run++;
			f++;
		end
		if (frames_run > 0) begin
			$display("TB PASSED");
			$finish;
		end else
			abort_run("the stimulus file held no frames");
	end
endmodule

// ==== verification/adc_frame_stim.txt ====
// sampling_points sampling_clk_increment last_frame bank_delay tready_mode missed overflow
// hex values; tready_mode 0 always high, 1 random, 2 low until the frame ends; zeros end
2 14 0 3 0 0 0
3 18 1 5 0 0 0
4 30 1 4 1 0 0
5 30 0 7 1 0 0
1 10 1 2 0 0 0
4 10 1 3 2 0 1
3 10 0 14 0 1 0
2 20 1 6 1 0 0
6 12 1 1a 1 1 0
3 14 1 2 0 0 0
0 0 0 0 0 0 0

// ==== filelist.f ====
+incdir+logic
logic/adc_frame_pkg.sv
logic/frame_sequencer.sv
logic/sample_capture.sv
logic/record_packer.sv
logic/stream_fifo.sv
logic/stream_out.sv
logic/adc_frame_top.sv
verification/tb_clock_gen.sv
verification/adc_frame_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f filelist.f --top-module adc_frame_tb
./obj_dir/Vadc_frame_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation finished cleanly"
